/* Bender.yml */
package:
  name: mips_decode

sources:
  - files:
      - mips_isa_pkg.sv
      - mips_ctrl_pkg.sv
      - register_file.sv
      - control_unit.sv
      - load_use_hazard.sv
      - instruction_decode.sv
      - decode_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_decode_top.sv

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic [mips_isa_pkg::NB_OPCODE-1:0]   i_opcode,
    input  logic [mips_isa_pkg::NB_FUNCT-1:0]    i_funct,
    output logic                                 o_jump,
    output logic                                 o_branch,
    output logic                                 o_reg_dst,
    output logic                                 o_mem_to_reg,
    output logic                                 o_mem_read,
    output logic                                 o_mem_write,
    output logic                                 o_zero_ext,
    output logic                                 o_reg_write,
    output logic [mips_ctrl_pkg::NB_ALU_SRC-1:0] o_alu_src,
    output logic [mips_ctrl_pkg::NB_ALU_OP-1:0]  o_alu_op
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    always_comb begin
        o_jump       = 1'b0;
        o_branch     = 1'b0;
        o_reg_dst    = 1'b0;
        o_mem_to_reg = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_zero_ext   = 1'b0;
        o_reg_write  = 1'b0;
        o_alu_src    = SRC_REG;
        o_alu_op     = ALUOP_ADD;

        case (i_opcode)
            OP_RTYPE: begin
                case (i_funct)
                    FN_JR: begin
                        o_jump = 1'b1;
                    end
                    FN_SLL: begin
                        o_reg_dst   = 1'b1;
                        o_reg_write = 1'b1;
                        o_alu_src   = SRC_SHAMT;
                        o_alu_op    = ALUOP_FUNCT;
                    end
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
                        o_reg_dst   = 1'b1;
                        o_reg_write = 1'b1;
                        o_alu_op    = ALUOP_FUNCT;
                    end
                    // unknown funct stays a nop
                    default: ;
                endcase
            end
            OP_LW: begin
                o_alu_src    = SRC_IMM;
                o_alu_op     = ALUOP_ADD;
                o_mem_read   = 1'b1;
                o_mem_to_reg = 1'b1;
                o_reg_write  = 1'b1;
            end
            OP_SW: begin
                o_alu_src   = SRC_IMM;
                o_alu_op    = ALUOP_ADD;
                o_mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                o_branch = 1'b1;
                o_alu_op = ALUOP_SUB;
            end
            OP_ADDI: begin
                o_alu_src   = SRC_IMM;
                o_alu_op    = ALUOP_ADD;
                o_reg_write = 1'b1;
            end
            // lui shifts the zero-extended value in EX
            OP_ANDI, OP_ORI, OP_LUI: begin
                o_alu_src   = SRC_IMM;
                o_alu_op    = ALUOP_LOGIC;
                o_reg_write = 1'b1;
                o_zero_ext  = 1'b1;
            end
            OP_J: begin
                o_jump = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* decode_top.sv */
`timescale 1ns/1ps

module decode_top (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    input  mips_isa_pkg::instr_u                 i_instruction,
    input  logic [mips_isa_pkg::NB_DATA-1:0]     i_pc4,
    input  logic                                 i_wb_we,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_wb_addr,
    input  logic [mips_isa_pkg::NB_DATA-1:0]     i_wb_data,
    output logic [mips_isa_pkg::NB_REG_ADDR-1:0] o_rs,
    output logic [mips_isa_pkg::NB_REG_ADDR-1:0] o_rt,
    output logic [mips_isa_pkg::NB_REG_ADDR-1:0] o_rd,
    output logic [mips_isa_pkg::NB_SHAMT-1:0]    o_shamt,
    output logic [mips_isa_pkg::NB_FUNCT-1:0]    o_funct,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_reg_da,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_reg_db,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_imm,
    output logic [mips_isa_pkg::NB_TARGET-1:0]   o_jump_target,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_pc4,
    output logic                                 o_jump,
    output logic                                 o_branch,
    output logic                                 o_reg_dst,
    output logic                                 o_mem_to_reg,
    output logic                                 o_mem_read,
    output logic                                 o_mem_write,
    output logic                                 o_reg_write,
    output logic [mips_ctrl_pkg::NB_ALU_SRC-1:0] o_alu_src,
    output logic [mips_ctrl_pkg::NB_ALU_OP-1:0]  o_alu_op,
    output logic                                 o_stall
);

    instruction_decode u_instruction_decode (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_instruction (i_instruction),
        .i_pc4         (i_pc4),
        .i_wb_we       (i_wb_we),
        .i_wb_addr     (i_wb_addr),
        .i_wb_data     (i_wb_data),
        .i_stall       (o_stall),
        .o_rs          (o_rs),
        .o_rt          (o_rt),
        .o_rd          (o_rd),
        .o_shamt       (o_shamt),
        .o_funct       (o_funct),
        .o_reg_da      (o_reg_da),
        .o_reg_db      (o_reg_db),
        .o_imm         (o_imm),
        .o_jump_target (o_jump_target),
        .o_pc4         (o_pc4),
        .o_jump        (o_jump),
        .o_branch      (o_branch),
        .o_reg_dst     (o_reg_dst),
        .o_mem_to_reg  (o_mem_to_reg),
        .o_mem_read    (o_mem_read),
        .o_mem_write   (o_mem_write),
        .o_reg_write   (o_reg_write),
        .o_alu_src     (o_alu_src),
        .o_alu_op      (o_alu_op)
    );

    // EX stage view is the ID/EX register itself
    load_use_hazard u_load_use_hazard (
        .i_ex_mem_read (o_mem_read),
        .i_ex_rt       (o_rt),
        .i_id_rs       (i_instruction.r.rs),
        .i_id_rt       (i_instruction.r.rt),
        .o_stall       (o_stall)
    );

endmodule

/* instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode (
    input  logic                                 clk,
    input  logic                                 i_rst_n,
    input  mips_isa_pkg::instr_u                 i_instruction,
    input  logic [mips_isa_pkg::NB_DATA-1:0]     i_pc4,
    input  logic                                 i_wb_we,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_wb_addr,
    input  logic [mips_isa_pkg::NB_DATA-1:0]     i_wb_data,
    input  logic                                 i_stall,
    output logic [mips_isa_pkg::NB_REG_ADDR-1:0] o_rs,
    output logic [mips_isa_pkg::NB_REG_ADDR-1:0] o_rt,
    output logic [mips_isa_pkg::NB_REG_ADDR-1:0] o_rd,
    output logic [mips_isa_pkg::NB_SHAMT-1:0]    o_shamt,
    output logic [mips_isa_pkg::NB_FUNCT-1:0]    o_funct,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_reg_da,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_reg_db,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_imm,
    output logic [mips_isa_pkg::NB_TARGET-1:0]   o_jump_target,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_pc4,
    output logic                                 o_jump,
    output logic                                 o_branch,
    output logic                                 o_reg_dst,
    output logic                                 o_mem_to_reg,
    output logic                                 o_mem_read,
    output logic                                 o_mem_write,
    output logic                                 o_reg_write,
    output logic [mips_ctrl_pkg::NB_ALU_SRC-1:0] o_alu_src,
    output logic [mips_ctrl_pkg::NB_ALU_OP-1:0]  o_alu_op
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic [NB_DATA-1:0]    rf_da;
    logic [NB_DATA-1:0]    rf_db;
    logic [NB_DATA-1:0]    imm_ext;
    logic                  c_jump;
    logic                  c_branch;
    logic                  c_reg_dst;
    logic                  c_mem_to_reg;
    logic                  c_mem_read;
    logic                  c_mem_write;
    logic                  c_zero_ext;
    logic                  c_reg_write;
    logic [NB_ALU_SRC-1:0] c_alu_src;
    logic [NB_ALU_OP-1:0]  c_alu_op;

    register_file u_register_file (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_we       (i_wb_we),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data),
        .i_rd_addr1 (i_instruction.r.rs),
        .i_rd_addr2 (i_instruction.r.rt),
        .o_rd_data1 (rf_da),
        .o_rd_data2 (rf_db)
    );

    control_unit u_control_unit (
        .i_opcode     (i_instruction.r.opcode),
        .i_funct      (i_instruction.r.funct),
        .o_jump       (c_jump),
        .o_branch     (c_branch),
        .o_reg_dst    (c_reg_dst),
        .o_mem_to_reg (c_mem_to_reg),
        .o_mem_read   (c_mem_read),
        .o_mem_write  (c_mem_write),
        .o_zero_ext   (c_zero_ext),
        .o_reg_write  (c_reg_write),
        .o_alu_src    (c_alu_src),
        .o_alu_op     (c_alu_op)
    );

    // logical ops and lui take the immediate unsigned
    assign imm_ext = c_zero_ext ?
                     {{(NB_DATA-NB_IMM){1'b0}}, i_instruction.i.imm} :
                     {{(NB_DATA-NB_IMM){i_instruction.i.imm[NB_IMM-1]}}, i_instruction.i.imm};

    // ID/EX data half also loads on a stall
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rs          <= '0;
            o_rt          <= '0;
            o_rd          <= '0;
            o_shamt       <= '0;
            o_funct       <= '0;
            o_reg_da      <= '0;
            o_reg_db      <= '0;
            o_imm         <= '0;
            o_jump_target <= '0;
            o_pc4         <= '0;
        end else begin
            o_rs          <= i_instruction.r.rs;
            o_rt          <= i_instruction.r.rt;
            o_rd          <= i_instruction.r.rd;
            o_shamt       <= i_instruction.r.shamt;
            o_funct       <= i_instruction.r.funct;
            o_reg_da      <= rf_da;
            o_reg_db      <= rf_db;
            o_imm         <= imm_ext;
            o_jump_target <= i_instruction.j.target;
            o_pc4         <= i_pc4;
        end
    end

    // control half takes a bubble on a stall
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_jump       <= 1'b0;
            o_branch     <= 1'b0;
            o_reg_dst    <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_reg_write  <= 1'b0;
            o_alu_src    <= '0;
            o_alu_op     <= '0;
        end else if (i_stall) begin
            o_jump       <= 1'b0;
            o_branch     <= 1'b0;
            o_reg_dst    <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_reg_write  <= 1'b0;
            o_alu_src    <= '0;
            o_alu_op     <= '0;
        end else begin
            o_jump       <= c_jump;
            o_branch     <= c_branch;
            o_reg_dst    <= c_reg_dst;
            o_mem_to_reg <= c_mem_to_reg;
            o_mem_read   <= c_mem_read;
            o_mem_write  <= c_mem_write;
            o_reg_write  <= c_reg_write;
            o_alu_src    <= c_alu_src;
            o_alu_op     <= c_alu_op;
        end
    end

endmodule

/* load_use_hazard.sv */
`timescale 1ns/1ps

module load_use_hazard (
    input  logic                                 i_ex_mem_read,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_ex_rt,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_id_rs,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_id_rt,
    output logic                                 o_stall
);

    logic rs_match;
    logic rt_match;
    logic ex_load;

    // a load into r0 never produces a value to wait for
    assign ex_load  = i_ex_mem_read && (i_ex_rt != '0);
    assign rs_match = (i_ex_rt == i_id_rs);
    assign rt_match = (i_ex_rt == i_id_rt);

    assign o_stall = ex_load && (rs_match || rt_match);

endmodule

/* mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

    localparam int NB_ALU_SRC = 2;
    localparam int NB_ALU_OP  = 2;

    // second ALU operand select
    localparam logic [NB_ALU_SRC-1:0] SRC_REG   = 2'd0;
    localparam logic [NB_ALU_SRC-1:0] SRC_IMM   = 2'd1;
    localparam logic [NB_ALU_SRC-1:0] SRC_SHAMT = 2'd2;

    // ALU operation class, EX refines FUNCT and LOGIC
    localparam logic [NB_ALU_OP-1:0] ALUOP_ADD   = 2'd0;
    localparam logic [NB_ALU_OP-1:0] ALUOP_SUB   = 2'd1;
    localparam logic [NB_ALU_OP-1:0] ALUOP_FUNCT = 2'd2;
    localparam logic [NB_ALU_OP-1:0] ALUOP_LOGIC = 2'd3;

endpackage

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    localparam int NB_DATA     = 32;
    localparam int NB_REG_ADDR = 5;
    localparam int NB_IMM      = 16;
    localparam int NB_TARGET   = 26;
    localparam int NB_OPCODE   = 6;
    localparam int NB_FUNCT    = 6;
    localparam int NB_SHAMT    = 5;

    // main opcodes
    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OPCODE-1:0] OP_J     = 6'h02;
    localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'h04;
    localparam logic [NB_OPCODE-1:0] OP_BNE   = 6'h05;
    localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'h08;
    localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'h0C;
    localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'h0D;
    localparam logic [NB_OPCODE-1:0] OP_LUI   = 6'h0F;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'h2B;

    // funct field of R-type
    localparam logic [NB_FUNCT-1:0] FN_SLL = 6'h00;
    localparam logic [NB_FUNCT-1:0] FN_JR  = 6'h08;
    localparam logic [NB_FUNCT-1:0] FN_ADD = 6'h20;
    localparam logic [NB_FUNCT-1:0] FN_SUB = 6'h22;
    localparam logic [NB_FUNCT-1:0] FN_AND = 6'h24;
    localparam logic [NB_FUNCT-1:0] FN_OR  = 6'h25;
    localparam logic [NB_FUNCT-1:0] FN_SLT = 6'h2A;

    typedef struct packed {
        logic [NB_OPCODE-1:0]   opcode;
        logic [NB_REG_ADDR-1:0] rs;
        logic [NB_REG_ADDR-1:0] rt;
        logic [NB_REG_ADDR-1:0] rd;
        logic [NB_SHAMT-1:0]    shamt;
        logic [NB_FUNCT-1:0]    funct;
    } r_fmt_t;

    typedef struct packed {
        logic [NB_OPCODE-1:0]   opcode;
        logic [NB_REG_ADDR-1:0] rs;
        logic [NB_REG_ADDR-1:0] rt;
        logic [NB_IMM-1:0]      imm;
    } i_fmt_t;

    typedef struct packed {
        logic [NB_OPCODE-1:0] opcode;
        logic [NB_TARGET-1:0] target;
    } j_fmt_t;

    // one instruction word, three views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_we,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_wr_addr,
    input  logic [mips_isa_pkg::NB_DATA-1:0]     i_wr_data,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_rd_addr1,
    input  logic [mips_isa_pkg::NB_REG_ADDR-1:0] i_rd_addr2,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_rd_data1,
    output logic [mips_isa_pkg::NB_DATA-1:0]     o_rd_data2
);
    import mips_isa_pkg::*;

    localparam int NUM_REGS = 2 ** NB_REG_ADDR;

    logic [NB_DATA-1:0] regs [NUM_REGS];
    logic               wr_valid;

    // r0 is never written
    assign wr_valid = i_we && (i_wr_addr != '0);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 0; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_valid) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // writeback in the same cycle wins over the stored word
    always_comb begin
        if (i_rd_addr1 == '0) begin
            o_rd_data1 = '0;
        end else if (wr_valid && (i_wr_addr == i_rd_addr1)) begin
            o_rd_data1 = i_wr_data;
        end else begin
            o_rd_data1 = regs[i_rd_addr1];
        end
    end

    always_comb begin
        if (i_rd_addr2 == '0) begin
            o_rd_data2 = '0;
        end else if (wr_valid && (i_wr_addr == i_rd_addr2)) begin
            o_rd_data2 = i_wr_data;
        end else begin
            o_rd_data2 = regs[i_rd_addr2];
        end
    end

endmodule

/* src.f */
mips_isa_pkg.sv
mips_ctrl_pkg.sv
register_file.sv
control_unit.sv
load_use_hazard.sv
instruction_decode.sv
decode_top.sv
tb_clock_gen.sv
tb_decode_top.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

/* tb_decode_top.sv */
`timescale 1ns/1ps

module tb_decode_top;
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS  = 400;
    localparam int RST_CYCLES = 2;
    localparam int MAX_CYCLES = NUM_TESTS + RST_CYCLES + 50;
    localparam int NB_CTRL    = 11;

    logic                   clk;
    logic                   i_rst_n;
    instr_u                 i_instruction;
    logic [NB_DATA-1:0]     i_pc4;
    logic                   i_wb_we;
    logic [NB_REG_ADDR-1:0] i_wb_addr;
    logic [NB_DATA-1:0]     i_wb_data;
    logic [NB_REG_ADDR-1:0] o_rs, o_rt, o_rd;
    logic [NB_SHAMT-1:0]    o_shamt;
    logic [NB_FUNCT-1:0]    o_funct;
    logic [NB_DATA-1:0]     o_reg_da, o_reg_db, o_imm, o_pc4;
    logic [NB_TARGET-1:0]   o_jump_target;
    logic                   o_jump, o_branch, o_reg_dst, o_mem_to_reg;
    logic                   o_mem_read, o_mem_write, o_reg_write, o_stall;
    logic [NB_ALU_SRC-1:0]  o_alu_src;
    logic [NB_ALU_OP-1:0]   o_alu_op;
    logic [NB_CTRL-1:0]     dut_ctrl;

    // reference model state
    logic [NB_DATA-1:0]     model_regs [32];
    logic [NB_DATA-1:0]     exp_da, exp_db, exp_imm, exp_pc4;
    logic [NB_REG_ADDR-1:0] exp_rs, exp_rt, exp_rd, exp_shamt;
    logic [NB_FUNCT-1:0]    exp_funct;
    logic [NB_TARGET-1:0]   exp_target;
    logic [NB_CTRL-1:0]     exp_ctrl;
    logic                   exp_stall;
    logic [31:0]            rng_state;
    int word_errors, reg_errors, ctrl_errors, stall_errors;
    int cycles = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock_gen (.o_clk(clk));

    decode_top UUT (.*);

    assign dut_ctrl = {o_jump, o_branch, o_reg_dst, o_mem_to_reg, o_mem_read,
                       o_mem_write, o_reg_write, o_alu_src, o_alu_op};

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // loads are favoured so hazards come up often
    function automatic logic [5:0] pick_opcode(input logic [7:0] sel, input logic [5:0] raw);
        if (sel[7:4] < 4'd3) begin
            return OP_LW;
        end
        if (sel[7:4] == 4'd3) begin
            return raw;
        end
        case (sel % 10)
            0: return OP_RTYPE;
            1: return OP_J;
            2: return OP_BEQ;
            3: return OP_BNE;
            4: return OP_ADDI;
            5: return OP_ANDI;
            6: return OP_ORI;
            7: return OP_LUI;
            8: return OP_SW;
            default: return OP_RTYPE;
        endcase
    endfunction

    function automatic logic [5:0] pick_funct(input logic [7:0] sel, input logic [5:0] raw);
        if (sel[3:0] == 4'd0) begin
            return raw;
        end
        case (sel[7:4] % 7)
            0: return FN_SLL;
            1: return FN_JR;
            2: return FN_ADD;
            3: return FN_SUB;
            4: return FN_AND;
            5: return FN_OR;
            default: return FN_SLT;
        endcase
    endfunction

    // mostly r0..r7
    function automatic logic [4:0] pick_reg(input logic [7:0] sel);
        if (sel[7:5] != 3'd0) begin
            return {2'b00, sel[2:0]};
        end
        return sel[4:0];
    endfunction

    // bit order: zero_ext jump branch reg_dst mem_to_reg mem_read mem_write reg_write
    function automatic logic [NB_CTRL:0] expected_ctrl(input logic [5:0] op,
                                                       input logic [5:0] fn);
        logic [NB_CTRL:0] c;
        c = '0;
        case (op)
            OP_RTYPE: begin
                case (fn)
                    FN_JR:  c = {8'b0100_0000, SRC_REG, ALUOP_ADD};
                    FN_SLL: c = {8'b0001_0001, SRC_SHAMT, ALUOP_FUNCT};
                    FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: begin
                        c = {8'b0001_0001, SRC_REG, ALUOP_FUNCT};
                    end
                    default: c = '0;
                endcase
            end
            OP_LW:                  c = {8'b0000_1101, SRC_IMM, ALUOP_ADD};
            OP_SW:                  c = {8'b0000_0010, SRC_IMM, ALUOP_ADD};
            OP_BEQ, OP_BNE:         c = {8'b0010_0000, SRC_REG, ALUOP_SUB};
            OP_ADDI:                c = {8'b0000_0001, SRC_IMM, ALUOP_ADD};
            OP_ANDI, OP_ORI, OP_LUI: c = {8'b1000_0001, SRC_IMM, ALUOP_LOGIC};
            OP_J:                   c = {8'b0100_0000, SRC_REG, ALUOP_ADD};
            default:                c = '0;
        endcase
        return c;
    endfunction

    function automatic logic [NB_DATA-1:0] model_read(input logic [NB_REG_ADDR-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_wb_we && (i_wb_addr == addr)) begin
            return i_wb_data;
        end
        return model_regs[addr];
    endfunction

    task automatic check_word(input string name, input logic [NB_DATA-1:0] expected,
                              input logic [NB_DATA-1:0] actual);
        if (actual !== expected) begin
            word_errors++;
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_reg(input string name, input logic [NB_REG_ADDR-1:0] expected,
                             input logic [NB_REG_ADDR-1:0] actual);
        if (actual !== expected) begin
            reg_errors++;
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_ctrl(input string name, input logic [NB_CTRL-1:0] expected,
                              input logic [NB_CTRL-1:0] actual);
        if (actual !== expected) begin
            ctrl_errors++;
            $display("FAIL %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_stall(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stall_errors++;
            $display("FAIL %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_outputs(input string name);
        check_reg({name, " o_rs"}, exp_rs, o_rs);
        check_reg({name, " o_rt"}, exp_rt, o_rt);
        check_reg({name, " o_rd"}, exp_rd, o_rd);
        check_reg({name, " o_shamt"}, exp_shamt, o_shamt);
        check_word({name, " o_funct"}, {26'b0, exp_funct}, {26'b0, o_funct});
        check_word({name, " o_reg_da"}, exp_da, o_reg_da);
        check_word({name, " o_reg_db"}, exp_db, o_reg_db);
        check_word({name, " o_imm"}, exp_imm, o_imm);
        check_word({name, " o_jump_target"}, {6'b0, exp_target}, {6'b0, o_jump_target});
        check_word({name, " o_pc4"}, exp_pc4, o_pc4);
        check_ctrl({name, " control"}, exp_ctrl, dut_ctrl);
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = lcg_next();
        i_instruction.r.opcode = pick_opcode(r[31:24], r[5:0]);
        i_instruction.r.funct  = pick_funct(r[23:16], r[11:6]);
        r = lcg_next();
        i_instruction.r.rs    = pick_reg(r[31:24]);
        i_instruction.r.rt    = pick_reg(r[23:16]);
        i_instruction.r.rd    = r[15:11];
        i_instruction.r.shamt = r[10:6];
        i_pc4 = lcg_next();
        r = lcg_next();
        i_wb_we   = r[31] | r[30];
        i_wb_addr = pick_reg(r[23:16]);
        i_wb_data = lcg_next();
    endtask

    // what the ID/EX register should hold after the next rising edge
    task automatic predict_next();
        logic [NB_CTRL:0] c;
        c = expected_ctrl(i_instruction.r.opcode, i_instruction.r.funct);
        exp_da = model_read(i_instruction.r.rs);
        exp_db = model_read(i_instruction.r.rt);
        if (c[NB_CTRL]) begin
            exp_imm = {16'b0, i_instruction.i.imm};
        end else begin
            exp_imm = {{16{i_instruction.i.imm[15]}}, i_instruction.i.imm};
        end
        exp_ctrl   = exp_stall ? '0 : c[NB_CTRL-1:0];
        exp_rs     = i_instruction.r.rs;
        exp_rt     = i_instruction.r.rt;
        exp_rd     = i_instruction.r.rd;
        exp_shamt  = i_instruction.r.shamt;
        exp_funct  = i_instruction.r.funct;
        exp_target = i_instruction.j.target;
        exp_pc4    = i_pc4;
        if (i_wb_we && (i_wb_addr != '0)) begin
            model_regs[i_wb_addr] = i_wb_data;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: decode run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        i_rst_n       = 1'b0;
        i_instruction = '0;
        i_pc4         = '0;
        i_wb_we       = 1'b0;
        i_wb_addr     = '0;
        i_wb_data     = '0;
        rng_state     = 32'd81;
        word_errors   = 0;
        reg_errors    = 0;
        ctrl_errors   = 0;
        stall_errors  = 0;
        {exp_da, exp_db, exp_imm, exp_pc4} = '0;
        {exp_rs, exp_rt, exp_rd, exp_shamt, exp_funct, exp_target} = '0;
        exp_ctrl  = '0;
        exp_stall = 1'b0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        check_outputs("reset");
        check_stall("reset o_stall", 1'b0, o_stall);
        i_rst_n = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            drive_random();
            exp_stall = exp_ctrl[6] && (exp_rt != '0) &&
                        ((exp_rt == i_instruction.r.rs) || (exp_rt == i_instruction.r.rt));
            #(CLK_PERIOD / 4);
            check_stall($sformatf("cycle %0d o_stall", t), exp_stall, o_stall);
            predict_next();
            @(negedge clk);
            check_outputs($sformatf("cycle %0d", t));
        end

        $display("errors: word=%0d reg=%0d ctrl=%0d stall=%0d",
                 word_errors, reg_errors, ctrl_errors, stall_errors);
        if (word_errors + reg_errors + ctrl_errors + stall_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
